/* design/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Response FIFO depth in 64-bit words, power of two
`define DMA_FIFO_DEPTH 16

// Longest burst per memory request
`define DMA_BURST_BEATS 4

// Outstanding memory requests allowed
`define DMA_MEM_CREDITS 2

// APB register byte offsets
`define DMA_REG_SRC  4'h0
`define DMA_REG_LEN  4'h4
`define DMA_REG_CTRL 4'h8
`define DMA_REG_STAT 4'hC

`define DMA_RESET_LEN 16'd256 // Words

`endif

/* design/dma_mem_pkg.sv */
package dma_mem_pkg;

	// Byte address on the memory port, always 8-byte aligned
	typedef logic [31:0] mem_addr_t;

	// Beats in one burst, 1 to 4
	typedef logic [2:0] mem_len_t;

	typedef logic [63:0] mem_data_t;

	// Read request, one per credit
	typedef struct packed {
		mem_addr_t addr;
		mem_len_t  len;
	} mem_req_t;

	// One returned beat
	typedef struct packed {
		mem_data_t data;
	} mem_rsp_t;

endpackage

/* design/dma_cfg_pkg.sv */
package dma_cfg_pkg;

	// APB byte offset
	typedef logic [3:0] reg_addr_t;

	// Transfer length in 64-bit words
	typedef logic [15:0] word_count_t;

	// Handed from the register block to the sequencer with start
	typedef struct packed {
		dma_mem_pkg::mem_addr_t src;
		word_count_t            len;
	} dma_cfg_t;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		DRAIN = 2'd2 // All words requested, waiting for credits
	} fetch_state_t;

endpackage

/* design/dma_regs.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  dma_cfg_pkg::reg_addr_t paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	input  logic                   last_pop,
	output logic                   start,
	output dma_cfg_pkg::dma_cfg_t  cfg
);
	import dma_mem_pkg::*;
	import dma_cfg_pkg::*;

	mem_addr_t   src_q;
	word_count_t len_q;
	logic        busy;
	logic        wr_access;
	logic        start_wr;
	logic        start_ok;
	mem_addr_t   src_aligned;

	// Access phase write
	assign wr_access = psel & penable & pwrite;

	assign start_wr = wr_access && (paddr == `DMA_REG_CTRL) && pwdata[0];

	// Drop starts while busy or with nothing to move
	assign start_ok = start_wr && !busy && (len_q != '0);

	assign src_aligned = {src_q[31:3], 3'b000}; // Word aligned source

	always_ff @(posedge clk) begin
		if (reset) begin
			src_q <= '0;
			len_q <= `DMA_RESET_LEN;
		end else if (wr_access) begin
			case (paddr)
				`DMA_REG_SRC: src_q <= pwdata;
				`DMA_REG_LEN: len_q <= pwdata[15:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			busy  <= 1'b0;
		end else begin
			start <= start_ok; // One cycle pulse
			if (start_ok)
				busy <= 1'b1;
			else if (last_pop)
				busy <= 1'b0; // Final word has left the FIFO
		end
	end

	// Read mux, valid whenever paddr is stable
	always_comb begin
		case (paddr)
			`DMA_REG_SRC:  prdata = src_aligned;
			`DMA_REG_LEN:  prdata = {16'h0000, len_q};
			`DMA_REG_STAT: prdata = {31'h0, busy};
			default:       prdata = '0; // CTRL start bit reads back 0
		endcase
	end

	// Registers hold still during a transfer, so cfg is steady at start
	assign cfg = '{src: src_aligned, len: len_q};

endmodule

/* design/dma_fetch_ctrl.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_fetch_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  dma_cfg_pkg::dma_cfg_t cfg,
	input  logic                  pop,
	output logic                  mem_req_valid,
	output dma_mem_pkg::mem_req_t mem_req,
	input  logic                  mem_credit
);
	import dma_mem_pkg::*;
	import dma_cfg_pkg::*;

	localparam int DEPTH   = `DMA_FIFO_DEPTH;
	localparam int BURST   = `DMA_BURST_BEATS;
	localparam int CREDITS = `DMA_MEM_CREDITS;
	localparam int CRED_W  = $clog2(CREDITS + 1);
	localparam int RSV_W   = $clog2(DEPTH + 1);

	fetch_state_t      state;
	mem_addr_t         next_addr;
	word_count_t       words_left; // Words not yet requested
	logic [CRED_W-1:0] credits;
	logic [RSV_W-1:0]  reserved;   // Requested but not yet popped
	logic [RSV_W-1:0]  space;
	mem_len_t          burst_len;
	logic              issue;
	logic              last_burst;

	// Full bursts, then the remainder
	always_comb begin
		if (words_left >= word_count_t'(BURST))
			burst_len = mem_len_t'(BURST);
		else
			burst_len = mem_len_t'(words_left);
	end

	// FIFO room left after every outstanding beat lands
	assign space = RSV_W'(DEPTH) - reserved;

	assign issue = (state == ISSUE) && (credits != '0) &&
		(space >= RSV_W'(burst_len));

	assign last_burst = (words_left == word_count_t'(burst_len));

	assign mem_req_valid = issue;
	assign mem_req       = '{addr: next_addr, len: burst_len};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start)
						state <= ISSUE;
				end
				ISSUE: begin
					if (issue && last_burst)
						state <= DRAIN;
				end
				DRAIN: begin
					// Every credit back means every beat has arrived
					if (credits == CRED_W'(CREDITS))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			words_left <= '0;
		end else if (state == IDLE && start) begin
			words_left <= cfg.len;
		end else if (issue) begin
			words_left <= words_left - word_count_t'(burst_len);
		end
	end

	// Eight bytes per beat
	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			next_addr <= cfg.src;
		else if (issue)
			next_addr <= next_addr + mem_addr_t'({burst_len, 3'b000});
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			credits  <= CRED_W'(CREDITS);
			reserved <= '0;
		end else begin
			credits  <= credits - CRED_W'(issue) + CRED_W'(mem_credit);
			reserved <= reserved + (issue ? RSV_W'(burst_len) : RSV_W'(0)) - RSV_W'(pop);
		end
	end

endmodule

/* design/dma_read_fifo.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_fifo (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     rsp_valid,
	input  dma_mem_pkg::mem_rsp_t    rsp,
	input  logic                     request,
	output dma_mem_pkg::mem_data_t   data,
	output logic                     data_ready,
	output logic                     pop,
	input  logic                     start,
	input  dma_cfg_pkg::word_count_t cfg_len,
	output logic                     last_pop
);
	import dma_mem_pkg::*;
	import dma_cfg_pkg::*;

	localparam int DEPTH = `DMA_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_data_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr; // Wraps on its own, depth is a power of two
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	word_count_t      total_len;
	word_count_t      delivered;

	assign pop = request && (count != '0); // Empty requests are dropped

	always_ff @(posedge clk) begin
		if (rsp_valid)
			mem[wr_ptr] <= rsp.data;
		if (pop)
			data <= mem[rd_ptr]; // Word shows one cycle after request
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			data_ready <= 1'b0;
		end else begin
			if (rsp_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count      <= count + CNT_W'(rsp_valid) - CNT_W'(pop);
			data_ready <= pop;
		end
	end

	// Delivered words of the current transfer
	always_ff @(posedge clk) begin
		if (reset) begin
			total_len <= '0;
			delivered <= '0;
			last_pop  <= 1'b0;
		end else begin
			last_pop <= pop && (word_count_t'(delivered + 1'b1) == total_len);
			if (start) begin
				total_len <= cfg_len;
				delivered <= '0;
			end else if (pop) begin
				delivered <= delivered + 1'b1;
			end
		end
	end

endmodule

/* design/dma_read_top.sv */
`timescale 1ns/1ps

module dma_read_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  dma_cfg_pkg::reg_addr_t paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   mem_req_valid,
	output dma_mem_pkg::mem_req_t  mem_req,
	input  logic                   mem_credit,
	input  logic                   mem_rsp_valid,
	input  dma_mem_pkg::mem_rsp_t  mem_rsp,
	input  logic                   request,
	output dma_mem_pkg::mem_data_t data,
	output logic                   data_ready
);
	import dma_cfg_pkg::*;

	logic     start;
	dma_cfg_t cfg;
	logic     pop;
	logic     last_pop;

	dma_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.last_pop (last_pop),
		.start    (start),
		.cfg      (cfg)
	);

	dma_fetch_ctrl u_fetch (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.cfg           (cfg),
		.pop           (pop),      // Frees reserved FIFO space
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_credit    (mem_credit)
	);

	dma_read_fifo u_fifo (
		.clk        (clk),
		.reset      (reset),
		.rsp_valid  (mem_rsp_valid),
		.rsp        (mem_rsp),
		.request    (request),
		.data       (data),
		.data_ready (data_ready),
		.pop        (pop),
		.start      (start),
		.cfg_len    (cfg.len),
		.last_pop   (last_pop)
	);

endmodule

/* tb/dma_read_checker.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   mem_req_valid,
	input dma_mem_pkg::mem_req_t  mem_req,
	input logic                   mem_credit,
	input logic                   mem_rsp_valid,
	input logic                   request,
	input dma_mem_pkg::mem_data_t data,
	input logic                   data_ready,
	input logic [31:0]            row_src,
	input logic [15:0]            row_len,
	input logic [7:0]             row_bursts,
	input logic                   row_begin,
	input logic                   row_end
);
	import dma_mem_pkg::*;

	localparam int BURST   = `DMA_BURST_BEATS;
	localparam int CREDITS = `DMA_MEM_CREDITS;

	int        errors = 0;
	int        words_checked = 0;
	int        bursts_checked = 0;
	int        word_idx = 0;    // Words seen in the current row
	int        bursts = 0;
	int        outstanding = 0;
	int        avail = 0;       // Delivered by memory and not yet taken
	int        req_left = 0;
	int        exp_len;
	mem_addr_t base_addr = '0;
	mem_addr_t exp_addr = '0;
	logic      exp_ready = 1'b0;

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task print_summary;
		$display("checker: %0d errors, %0d words and %0d bursts checked",
			errors, words_checked, bursts_checked);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			outstanding = 0;
			avail = 0;
			exp_ready = 1'b0;
		end else begin
			if (row_begin) begin
				base_addr = row_src & ~32'h7;
				exp_addr = base_addr;
				req_left = int'(row_len);
				word_idx = 0;
				bursts = 0;
			end
			if (mem_req_valid) begin
				bursts++;
				if (req_left == 0) begin
					report_failure("memory request with no words left in the row");
				end else begin
					exp_len = (req_left >= BURST) ? BURST : req_left;
					check_value("mem_req.addr", 64'(mem_req.addr), 64'(exp_addr));
					check_value("mem_req.len", 64'(mem_req.len), 64'(exp_len));
					exp_addr = exp_addr + 32'(exp_len * 8);
					req_left -= exp_len;
					bursts_checked++;
				end
			end
			outstanding = outstanding + int'(mem_req_valid) - int'(mem_credit);
			if (outstanding > CREDITS)
				report_failure($sformatf("%0d memory requests outstanding", outstanding));
			check_value("data_ready", 64'(data_ready), 64'(exp_ready));
			if (data_ready) begin
				check_value("data", data, {32'hD0A0_0000, base_addr + 32'(word_idx * 8)});
				word_idx++;
				words_checked++;
				if (word_idx > int'(row_len))
					report_failure("more words delivered than the row length");
			end
			// One cycle request to data_ready
			exp_ready = request && (avail != 0);
			avail = avail + int'(mem_rsp_valid) - int'(exp_ready);
			if (row_end) begin
				check_value("words delivered", 64'(word_idx), 64'(row_len));
				check_value("burst count", 64'(bursts), 64'(row_bursts));
				check_value("words left to request", 64'(req_left), 64'd0);
			end
		end
	end

endmodule

/* tb/dma_read_tb.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_tb;
	import dma_mem_pkg::*;
	import dma_cfg_pkg::*;

	typedef struct packed {
		logic [31:0] src;
		logic [15:0] len;
		logic [2:0]  density; // Requests per 8 cycles
		logic [7:0]  bursts;
	} row_t;

	localparam int NUM_ROWS = 6;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	reg_addr_t   paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        mem_req_valid;
	mem_req_t    mem_req;
	logic        mem_credit;
	logic        mem_rsp_valid;
	mem_rsp_t    mem_rsp;
	logic        request;
	mem_data_t   data;
	logic        data_ready;

	row_t        rows [NUM_ROWS];
	logic [31:0] row_src;
	logic [15:0] row_len;
	logic [7:0]  row_bursts;
	logic        row_begin;
	logic        row_end;
	logic [2:0]  density;
	logic        consume_on;
	logic [31:0] mem_lfsr;
	logic [31:0] cons_lfsr;
	mem_req_t    req_q [$];

	dma_read_top UUT (.*);

	dma_read_checker dma_read_checker (.*);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function logic [7:0] mem_rand(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			mem_lfsr = lfsr_next(mem_lfsr);
			r = {r[6:0], mem_lfsr[0]};
		end
		return r;
	endfunction

	function logic [7:0] cons_rand(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			cons_lfsr = lfsr_next(cons_lfsr);
			r = {r[6:0], cons_lfsr[0]};
		end
		return r;
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic apb_write(input reg_addr_t addr, input logic [31:0] wdata);
		@(posedge clk);
		#1 psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1 penable = 1'b1; // Access phase
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input reg_addr_t addr, output logic [31:0] rdata);
		@(posedge clk);
		#1 psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1 penable = 1'b1;
		#4 rdata = prdata; // Mid access phase
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	always @(posedge clk) begin
		if (mem_req_valid)
			req_q.push_back(mem_req);
	end

	// Responses in request order after a random gap
	initial begin
		mem_req_t req;
		logic [7:0] gap;
		forever begin
			@(posedge clk);
			#1;
			if (req_q.size() != 0) begin
				req = req_q.pop_front();
				gap = mem_rand(3);
				repeat (int'(gap)) begin
					@(posedge clk);
					#1;
				end
				for (int i = 0; i < int'(req.len); i++) begin
					mem_rsp_valid = 1'b1;
					mem_rsp.data = {32'hD0A0_0000, req.addr + 32'(i * 8)};
					@(posedge clk);
					#1;
				end
				mem_rsp_valid = 1'b0;
				mem_credit = 1'b1; // Burst done
				@(posedge clk);
				#1 mem_credit = 1'b0;
			end
		end
	end

	// Request decided at the edge and driven 1 ns later
	initial begin
		logic req_next;
		forever begin
			@(posedge clk);
			req_next = consume_on && (cons_rand(3) < {5'd0, density});
			#1 request = req_next;
		end
	end

	// Watchdog sized from the table
	initial begin
		int limit;
		@(negedge reset);
		limit = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 200 + 40 * int'(rows[r].len);
		repeat (limit) @(posedge clk);
		$display("timeout: the transfers did not finish within %0d cycles", limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		rows[0] = '{32'h0000_1000, 16'd8, 3'd7, 8'd2};
		rows[1] = '{32'h0000_2003, 16'd10, 3'd2, 8'd3}; // Unaligned source
		rows[2] = '{32'h0000_4000, 16'd1, 3'd5, 8'd1};
		rows[3] = '{32'h0000_8000, 16'd0, 3'd4, 8'd0};
		rows[4] = '{32'h0000_A010, 16'd37, 3'd1, 8'd10}; // Slow consumer
		rows[5] = '{32'hFFF8_0000, 16'd7, 3'd6, 8'd2};
		mem_lfsr = 32'd89345;
		cons_lfsr = 32'd89345;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mem_credit = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp = '0;
		request = 1'b0;
		density = '0;
		consume_on = 1'b0;
		row_src = '0;
		row_len = '0;
		row_bursts = '0;
		row_begin = 1'b0;
		row_end = 1'b0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge clk);
			#1 row_src = rows[r].src;
			row_len = rows[r].len;
			row_bursts = rows[r].bursts;
			density = rows[r].density;
			consume_on = 1'b1;
			row_begin = 1'b1;
			@(posedge clk);
			#1 row_begin = 1'b0;
			apb_write(`DMA_REG_SRC, rows[r].src);
			apb_write(`DMA_REG_LEN, {16'h0000, rows[r].len});
			apb_read(`DMA_REG_SRC, rd);
			dma_read_checker.check_value("SRC readback", 64'(rd), 64'(rows[r].src & ~32'h7));
			apb_read(`DMA_REG_LEN, rd);
			dma_read_checker.check_value("LEN readback", 64'(rd), 64'(rows[r].len));
			apb_write(`DMA_REG_CTRL, 32'h1);
			apb_write(`DMA_REG_CTRL, 32'h1); // Lands while busy
			apb_read(`DMA_REG_CTRL, rd);
			dma_read_checker.check_value("CTRL readback", 64'(rd), 64'd0);
			do
				apb_read(`DMA_REG_STAT, rd);
			while (rd[0]);
			dma_read_checker.check_value("words at idle",
				64'(dma_read_checker.word_idx), 64'(rows[r].len));
			repeat (20) @(posedge clk); // Requests here find nothing left
			#1 row_end = 1'b1;
			@(posedge clk);
			#1 row_end = 1'b0;
			consume_on = 1'b0;
		end
		repeat (5) @(posedge clk);
		#1 dma_read_checker.print_summary();
		if (dma_read_checker.errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+design
design/dma_mem_pkg.sv
design/dma_cfg_pkg.sv
design/dma_regs.sv
design/dma_fetch_ctrl.sv
design/dma_read_fifo.sv
design/dma_read_top.sv
tb/dma_read_checker.sv
tb/dma_read_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DMA read engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dma_read_tb -f files.f \
	--Mdir obj_dir -o sim_dma_read
./obj_dir/sim_dma_read | tee sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
grep -q "All checks passed" sim.log
